/* Bender.yml */
package:
  name: fft_peak

sources:
  - rtl/dsp_num_pkg.sv
  - rtl/fft_cfg_pkg.sv
  - rtl/fft_ctrl.sv
  - rtl/twiddle_rom.sv
  - rtl/sdf_butterfly.sv
  - rtl/sdf_stage.sv
  - rtl/bin_buffer.sv
  - rtl/peak_finder.sv
  - rtl/fft_top.sv
  - target: simulation
    files:
      - dv/tb_clock.sv
      - dv/fft_sva.sv
      - dv/fft_tb.sv

/* build.f */
rtl/dsp_num_pkg.sv
rtl/fft_cfg_pkg.sv
rtl/fft_ctrl.sv
rtl/twiddle_rom.sv
rtl/sdf_butterfly.sv
rtl/sdf_stage.sv
rtl/bin_buffer.sv
rtl/peak_finder.sv
rtl/fft_top.sv
dv/tb_clock.sv
dv/fft_sva.sv
dv/fft_tb.sv

/* dv/fft_sva.sv */
`timescale 1ns/1ps

module fft_sva import fft_cfg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic fft_valid,
	input logic done
);

	a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		fft_valid |=> !fft_valid)
		else $error("fft_valid stayed high for more than one clock");

	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
		else $error("done stayed high for more than one clock");

	a_done_follows: assert property (@(posedge clk) disable iff (rst)
		fft_valid |=> done)
		else $error("done did not follow fft_valid by one clock");

	a_done_cause: assert property (@(posedge clk) disable iff (rst)
		done |-> $past(fft_valid))
		else $error("done rose without fft_valid one clock before");

	// A frame takes sixteen samples, so pulses are at least sixteen clocks apart
	a_frame_spacing: assert property (@(posedge clk) disable iff (rst)
		fft_valid |=> (!fft_valid) [*N_POINTS-1])
		else $error("fft_valid pulses closer together than one frame of samples");

endmodule

/* dv/fft_tb.sv */
`timescale 1ns/1ps

module fft_tb import dsp_num_pkg::*, fft_cfg_pkg::*; ();

	typedef enum logic [1:0] {ZERO, DC, IMPULSE, ALT} frame_kind_t;

	typedef struct packed {
		frame_kind_t kind;
		logic        rnd; // Amplitude comes from $random
		sample_t     amp;
	} row_t;

	localparam int  N_ROWS = 10;
	localparam int  N_FRAMES = N_ROWS + 1; // Zero flush frame drains the last row
	localparam int  CYCLE_LIMIT = 3 * N_FRAMES * N_POINTS + 200;
	localparam time DRIVE_DLY = 2;

	localparam row_t STIM [N_ROWS] = '{
		'{ZERO, 1'b0, 16'sd0}, '{DC, 1'b0, 16'sd100}, '{IMPULSE, 1'b0, 16'sd1000},
		'{ALT, 1'b0, 16'sd50}, '{DC, 1'b1, 16'sd0}, '{ALT, 1'b1, 16'sd0},
		'{IMPULSE, 1'b0, -16'sd2047}, '{DC, 1'b0, -16'sd2047},
		'{ALT, 1'b0, 16'sd2047}, '{IMPULSE, 1'b1, 16'sd0}
	};

	logic     clk;
	logic     rst;
	logic     data_valid;
	sample_t  data;
	bin_vec_t fft_d;
	logic     fft_valid;
	bin_idx_t freq;
	logic     done;

	integer   seed = 18706;
	sample_t  amp [N_ROWS];
	int       value_errs = 0;
	int       frame_errs = 0;
	int       accepted = 0; // Samples the DUT has taken
	int       valid_seen = 0;
	int       done_seen = 0;
	int       cycles = 0;
	logic     valid_d = 1'b0;

	tb_clock #(.PERIOD(40)) clk_i (.clk(clk));

	fft_top fft_top_i (
		.clk       (clk),
		.rst       (rst),
		.data_valid(data_valid),
		.data      (data),
		.fft_d     (fft_d),
		.fft_valid (fft_valid),
		.freq      (freq),
		.done      (done)
	);

	bind fft_top fft_sva sva_i (
		.clk      (clk),
		.rst      (rst),
		.fft_valid(fft_valid),
		.done     (done)
	);

	function automatic sample_t sample_value(frame_kind_t kind, sample_t a, int n);
		case (kind)
			DC:      return a;
			IMPULSE: return (n == 0) ? a : sample_t'(0);
			ALT:     return n[0] ? sample_t'(-a) : a; // Starts at +A
			default: return sample_t'(0);
		endcase
	endfunction

	function automatic bin_vec_t expected_bins(frame_kind_t kind, sample_t a);
		bin_vec_t v;
		v = '0;
		case (kind)
			DC:      v[0].re = sample_t'(16 * a);
			IMPULSE:
				for (int k = 0; k < N_POINTS; k++)
					v[k].re = a; // Flat spectrum
			ALT:     v[N_POINTS/2].re = sample_t'(16 * a);
			default: v = '0;
		endcase
		return v;
	endfunction

	function automatic bin_idx_t expected_freq(frame_kind_t kind, sample_t a);
		if (kind == ALT && a != 0)
			return bin_idx_t'(N_POINTS / 2);
		return '0; // Bin 0 wins or all bins tie
	endfunction

	task automatic check_bin(string name, bin_t act, bin_t exp);
		if (act !== exp)
		begin
			value_errs++;
			$display("Fail at %0t: %s expected re %0d im %0d, got re %0d im %0d",
				$time, name, exp.re, exp.im, act.re, act.im);
		end
	endtask

	task automatic check_idx(string name, bin_idx_t act, bin_idx_t exp);
		if (act !== exp)
		begin
			value_errs++;
			$display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(string name, logic act, logic exp);
		if (act !== exp)
		begin
			value_errs++;
			$display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_idle();
		check_bit("fft_valid", fft_valid, 1'b0);
		check_bit("done", done, 1'b0);
		check_idx("freq", freq, '0);
		for (int k = 0; k < N_POINTS; k++)
			check_bin($sformatf("fft_d[%0d]", k), fft_d[k], '0);
	endtask

	task automatic check_frame();
		bin_vec_t exp;
		if (valid_seen >= N_ROWS)
		begin
			frame_errs++;
			$display("At %0t fft_valid pulsed with no table frame left", $time);
		end
		else
		begin
			// Frame k completes on its sample 16k+30
			if (accepted != N_POINTS * valid_seen + 2 * N_POINTS - 1)
			begin
				frame_errs++;
				$display("At %0t frame %0d completed after %0d samples, not %0d",
					$time, valid_seen, accepted, N_POINTS * valid_seen + 2 * N_POINTS - 1);
			end
			exp = expected_bins(STIM[valid_seen].kind, amp[valid_seen]);
			for (int k = 0; k < N_POINTS; k++)
				check_bin($sformatf("fft_d[%0d]", k), fft_d[k], exp[k]);
		end
		valid_seen++;
	endtask

	task automatic send_frame(int f);
		frame_kind_t kind;
		sample_t     a;
		int          gap;
		kind = (f < N_ROWS) ? STIM[f].kind : ZERO;
		a = (f < N_ROWS) ? amp[f] : sample_t'(0);
		for (int n = 0; n < N_POINTS; n++)
		begin
			data_valid = 1'b1;
			data = sample_value(kind, a, n);
			@(posedge clk);
			#DRIVE_DLY;
			gap = {$random(seed)} % 3;
			data_valid = 1'b0;
			repeat (gap)
			begin
				@(posedge clk);
				#DRIVE_DLY;
			end
		end
	endtask

	task automatic print_counts();
		$display("Errors: %0d value, %0d framing", value_errs, frame_errs);
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (!rst && data_valid)
			accepted <= accepted + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			print_counts();
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Outputs are settled at the falling edge
	always @(negedge clk)
	begin
		if (rst)
			valid_d = 1'b0;
		else
		begin
			check_bit("done", done, valid_d);
			if (fft_valid)
				check_frame();
			if (done)
			begin
				if (done_seen < N_ROWS)
					check_idx("freq", freq, expected_freq(STIM[done_seen].kind, amp[done_seen]));
				done_seen++;
			end
			valid_d = fft_valid;
		end
	end

	initial
	begin
		rst = 1'b1;
		data_valid = 1'b0;
		data = '0;
		for (int r = 0; r < N_ROWS; r++)
			amp[r] = STIM[r].rnd ? sample_t'($random(seed) % 2048) : STIM[r].amp;
		repeat (16)
			@(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		check_idle();
		for (int f = 0; f < N_FRAMES; f++)
			send_frame(f);
		wait (done_seen >= N_ROWS);
		repeat (4)
			@(posedge clk);
		if (valid_seen != N_ROWS)
		begin
			frame_errs++;
			$display("Saw %0d fft_valid pulses for %0d table frames", valid_seen, N_ROWS);
		end
		print_counts();
		if (value_errs + frame_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter time PERIOD = 40
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

endmodule

/* rtl/bin_buffer.sv */
`timescale 1ns/1ps

module bin_buffer import dsp_num_pkg::*, fft_cfg_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     data_valid,
	input  bin_idx_t slot,
	input  cplx_t    din,
	output bin_vec_t fft_d
);

	// Serial bit-reversed stream into natural-order registers
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			fft_d <= '0;
		else if (data_valid)
			fft_d[BIN_ORDER[slot]] <= to_bin(din);
	end

endmodule

/* rtl/dsp_num_pkg.sv */
package dsp_num_pkg;

	localparam int SAMPLE_W = 16;
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	localparam int INT_W = 24; // Sample in the top bits, 8 fraction bits below
	localparam int FRAC_W = INT_W - SAMPLE_W;
	typedef struct packed {
		logic signed [INT_W-1:0] re;
		logic signed [INT_W-1:0] im;
	} cplx_t;

	localparam int TW_W = 32;
	localparam int TW_FRAC = 16; // 1.0 is 32'h0001_0000
	typedef struct packed {
		logic signed [TW_W-1:0] re;
		logic signed [TW_W-1:0] im;
	} twiddle_t;

	localparam int PROD_W = INT_W + TW_W + 2; // Headroom for the three-multiply sums

	typedef struct packed {
		logic signed [SAMPLE_W-1:0] re;
		logic signed [SAMPLE_W-1:0] im;
	} bin_t;

	typedef logic [2*SAMPLE_W:0] power_t; // re^2 + im^2, never negative

	// Drops the fraction bits of an internal word
	function automatic bin_t to_bin(cplx_t c);
		return '{re: c.re[INT_W-1 -: SAMPLE_W], im: c.im[INT_W-1 -: SAMPLE_W]};
	endfunction

endpackage

/* rtl/fft_cfg_pkg.sv */
package fft_cfg_pkg;

	import dsp_num_pkg::*;

	localparam int N_POINTS = 16;
	localparam int STAGES = 4;
	localparam int CNT_W = 4;
	localparam int TW_IDX_W = CNT_W - 1; // Half-circle table, 8 entries

	typedef logic [CNT_W-1:0] bin_idx_t;
	typedef bin_t [N_POINTS-1:0] bin_vec_t; // Indexed by natural bin number

	// cos(2*pi*k/16) and -sin(2*pi*k/16) for k = 0..7
	localparam twiddle_t TWIDDLE_TABLE [N_POINTS/2] = '{
		'{32'sh0001_0000, 32'sh0000_0000}, '{32'sh0000_EC83, 32'shFFFF_9E09},
		'{32'sh0000_B504, 32'shFFFF_4AFC}, '{32'sh0000_61F7, 32'shFFFF_137D},
		'{32'sh0000_0000, 32'shFFFF_0000}, '{32'shFFFF_9E09, 32'shFFFF_137D},
		'{32'shFFFF_4AFC, 32'shFFFF_4AFC}, '{32'shFFFF_137D, 32'shFFFF_9E09}
	};

	// Per rotating stage, the index one step before the first twiddle
	localparam logic [TW_IDX_W-1:0] TW_INIT [STAGES-1] = '{3'd7, 3'd6, 3'd4};
	localparam logic [TW_IDX_W-1:0] TW_STEP [STAGES-1] = '{3'd1, 3'd2, 3'd4};

	// Stage 3 emits bins in bit-reversed order
	localparam bin_idx_t BIN_ORDER [N_POINTS] = '{
		4'd0, 4'd8, 4'd4, 4'd12, 4'd2, 4'd10, 4'd6, 4'd14,
		4'd1, 4'd9, 4'd5, 4'd13, 4'd3, 4'd11, 4'd7, 4'd15
	};

endpackage

/* rtl/fft_ctrl.sv */
`timescale 1ns/1ps

module fft_ctrl import fft_cfg_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              data_valid,
	output logic [STAGES-1:0] add_sel,
	output bin_idx_t          slot,
	output logic              frame_end,
	output logic              fft_valid
);

	logic [CNT_W-1:0] cnt; // Valid samples seen, mod 16
	logic             primed; // First frame fully received

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cnt <= '0;
			primed <= 1'b0;
			fft_valid <= 1'b0;
		end
		else
		begin
			if (data_valid)
				cnt <= cnt + 1'b1;
			if (data_valid && cnt == CNT_W'(N_POINTS - 1))
				primed <= 1'b1;
			fft_valid <= frame_end;
		end
	end

	// Stage 0 toggles slowest
	for (genvar s = 0; s < STAGES; s++)
	begin : g_sel
		assign add_sel[s] = cnt[CNT_W-1-s];
	end

	assign slot = cnt + 1'b1; // Slot 0 leaves stage 3 on sample 15 of a frame
	assign frame_end = data_valid && primed && slot == bin_idx_t'(N_POINTS - 1);

endmodule

/* rtl/fft_top.sv */
`timescale 1ns/1ps

module fft_top import dsp_num_pkg::*, fft_cfg_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     data_valid,
	input  sample_t  data,
	output bin_vec_t fft_d,
	output logic     fft_valid,
	output bin_idx_t freq,
	output logic     done
);

	logic [STAGES-1:0]    add_sel;
	bin_idx_t             slot;
	logic                 frame_end;
	twiddle_t [STAGES-1:0] tw_all; // Last entry feeds the stage without twiddle
	cplx_t                chain [STAGES+1];

	assign chain[0] = '{re: {data, {FRAC_W{1'b0}}}, im: '0};
	assign tw_all[STAGES-1] = TWIDDLE_TABLE[0];

	fft_ctrl ctrl_i (
		.clk       (clk),
		.rst       (rst),
		.data_valid(data_valid),
		.add_sel   (add_sel),
		.slot      (slot),
		.frame_end (frame_end),
		.fft_valid (fft_valid)
	);

	twiddle_rom rom_i (
		.clk       (clk),
		.rst       (rst),
		.data_valid(data_valid),
		.add_sel   (add_sel[STAGES-2:0]),
		.tw        (tw_all[STAGES-2:0])
	);

	for (genvar s = 0; s < STAGES; s++)
	begin : g_stage
		sdf_stage #(
			.DEPTH (N_POINTS >> (s + 1)),
			.USE_TW(s != STAGES - 1)
		) stage_i (
			.clk       (clk),
			.rst       (rst),
			.data_valid(data_valid),
			.add_sel   (add_sel[s]),
			.din       (chain[s]),
			.tw        (tw_all[s]),
			.dout      (chain[s+1])
		);
	end

	bin_buffer buf_i (
		.clk       (clk),
		.rst       (rst),
		.data_valid(data_valid),
		.slot      (slot),
		.din       (chain[STAGES]),
		.fft_d     (fft_d)
	);

	peak_finder peak_i (
		.clk       (clk),
		.rst       (rst),
		.data_valid(data_valid),
		.slot      (slot),
		.din       (chain[STAGES]),
		.frame_end (frame_end),
		.freq      (freq),
		.done      (done)
	);

endmodule

/* rtl/peak_finder.sv */
`timescale 1ns/1ps

module peak_finder import dsp_num_pkg::*, fft_cfg_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     data_valid,
	input  bin_idx_t slot,
	input  cplx_t    din,
	input  logic     frame_end,
	output bin_idx_t freq,
	output logic     done
);

	bin_t                         bin_q;
	bin_idx_t                     slot_q;
	logic                         valid_q;
	logic                         end_q;
	logic signed [2*SAMPLE_W-1:0] sq_re;
	logic signed [2*SAMPLE_W-1:0] sq_im;
	power_t                       power;
	power_t                       best_pow;
	bin_idx_t                     best_idx;
	logic                         take;

	always_ff @(posedge clk)
	begin
		if (data_valid)
		begin
			bin_q <= to_bin(din);
			slot_q <= slot;
		end
	end

	assign sq_re = bin_q.re * bin_q.re;
	assign sq_im = bin_q.im * bin_q.im;
	assign power = {1'b0, sq_re} + {1'b0, sq_im};
	assign take = (slot_q == '0) || (power > best_pow); // Ties keep the earlier bin

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			valid_q <= 1'b0;
			end_q <= 1'b0;
			best_pow <= '0;
			best_idx <= '0;
			freq <= '0;
			done <= 1'b0;
		end
		else
		begin
			valid_q <= data_valid;
			end_q <= frame_end;
			done <= end_q; // One clock behind fft_valid
			if (valid_q && take)
			begin
				best_pow <= power;
				best_idx <= BIN_ORDER[slot_q];
			end
			if (end_q)
				freq <= take ? BIN_ORDER[slot_q] : best_idx; // Last bin still counts
		end
	end

endmodule

/* rtl/sdf_butterfly.sv */
`timescale 1ns/1ps

module sdf_butterfly import dsp_num_pkg::*; #(
	parameter bit USE_TW = 1'b1
) (
	input  logic     add_sel,
	input  cplx_t    fb,
	input  cplx_t    din,
	input  twiddle_t tw,
	output cplx_t    to_delay,
	output cplx_t    dout
);

	cplx_t rot; // Delayed value after the optional rotation

	if (USE_TW)
	begin : g_tw
		logic signed [INT_W:0]    re_minus_im;
		logic signed [INT_W:0]    re_plus_im;
		logic signed [TW_W:0]     w_diff;
		logic signed [PROD_W-1:0] shared;
		logic signed [PROD_W-1:0] prod_re;
		logic signed [PROD_W-1:0] prod_im;

		// Three multipliers instead of four
		assign re_minus_im = fb.re - fb.im;
		assign re_plus_im = fb.re + fb.im;
		assign w_diff = tw.re - tw.im;
		assign shared = fb.im * w_diff;
		assign prod_re = tw.re * re_minus_im + shared;
		assign prod_im = tw.im * re_plus_im + shared;
		assign rot = '{re: prod_re[TW_FRAC +: INT_W], im: prod_im[TW_FRAC +: INT_W]};
	end
	else
	begin : g_plain
		assign rot = fb; // W0 only, nothing to rotate
	end

	always_comb
	begin
		if (add_sel)
		begin
			dout = '{re: fb.re + din.re, im: fb.im + din.im};
			to_delay = '{re: fb.re - din.re, im: fb.im - din.im}; // Older minus newer
		end
		else
		begin
			dout = rot;
			to_delay = din;
		end
	end

endmodule

/* rtl/sdf_stage.sv */
`timescale 1ns/1ps

module sdf_stage import dsp_num_pkg::*; #(
	parameter int DEPTH  = 8,
	parameter bit USE_TW = 1'b1
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     data_valid,
	input  logic     add_sel,
	input  cplx_t    din,
	input  twiddle_t tw,
	output cplx_t    dout
);

	cplx_t dl [DEPTH]; // Feedback delay line
	cplx_t to_delay;

	sdf_butterfly #(
		.USE_TW(USE_TW)
	) bfly_i (
		.add_sel (add_sel),
		.fb      (dl[DEPTH-1]),
		.din     (din),
		.tw      (tw),
		.to_delay(to_delay),
		.dout    (dout)
	);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < DEPTH; i++)
				dl[i] <= '0;
		end
		else if (data_valid)
		begin
			dl[0] <= to_delay;
			for (int i = 1; i < DEPTH; i++)
				dl[i] <= dl[i-1];
		end
	end

endmodule

/* rtl/twiddle_rom.sv */
`timescale 1ns/1ps

module twiddle_rom import dsp_num_pkg::*, fft_cfg_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   data_valid,
	input  logic [STAGES-2:0]      add_sel,
	output twiddle_t [STAGES-2:0]  tw
);

	logic [TW_IDX_W-1:0] idx [STAGES-1];
	logic [TW_IDX_W-1:0] idx_next [STAGES-1];

	// The table is read at the index this sample moves to
	always_comb
	begin
		for (int s = 0; s < STAGES-1; s++)
		begin
			idx_next[s] = idx[s] + TW_STEP[s];
			tw[s] = TWIDDLE_TABLE[idx_next[s]];
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int s = 0; s < STAGES-1; s++)
				idx[s] <= TW_INIT[s];
		end
		else if (data_valid)
		begin
			for (int s = 0; s < STAGES-1; s++)
			begin
				if (!add_sel[s])
					idx[s] <= idx_next[s]; // Advances only while the stage rotates
			end
		end
	end

endmodule
